// ==== common/ahb_in_consts.svh ====
// AHB input stage constants: bus field widths and wrap-boundary check limits
`ifndef AHB_IN_CONSTS_SVH
`define AHB_IN_CONSTS_SVH

// ---------------------------------------------------------------------------
// Bus field widths
// ---------------------------------------------------------------------------

// Address bus width
`define AHB_ADDR_W 32

// HPROT protection code width
`define AHB_PROT_W 4

// HMASTER master number width
`define AHB_MASTER_W 4

// ---------------------------------------------------------------------------
// Wrap-boundary check
// ---------------------------------------------------------------------------

// Beat offset width, enough for a 16-beat wrap
`define AHB_OFS_W 4

// Largest HSIZE (log2 of bytes) that gets a scaled offset
// Anything wider than 64 bits falls back to a byte offset
`define AHB_MAX_SIZE_LOG2 3

`endif

// ==== common/ahb_in_pkg.sv ====
// AHB input stage types: field vectors, bus encodings and address/control bundle
`include "ahb_in_consts.svh"

package ahb_in_pkg;

  // Field vectors
  typedef logic [`AHB_ADDR_W-1:0]   haddr_t;    // Bus address
  typedef logic [`AHB_PROT_W-1:0]   hprot_t;    // Protection code
  typedef logic [`AHB_MASTER_W-1:0] hmaster_t;  // Master number
  typedef logic [`AHB_OFS_W-1:0]    beat_ofs_t; // Beat offset in largest wrap

  // HTRANS encoding
  typedef enum logic [1:0] {
    TRN_IDLE   = 2'b00,
    TRN_BUSY   = 2'b01,
    TRN_NONSEQ = 2'b10,
    TRN_SEQ    = 2'b11
  } htrans_e;

  // HBURST encoding, wrap types have bit 0 clear
  typedef enum logic [2:0] {
    BUR_SINGLE = 3'b000,
    BUR_INCR   = 3'b001,
    BUR_WRAP4  = 3'b010,
    BUR_INCR4  = 3'b011,
    BUR_WRAP8  = 3'b100,
    BUR_INCR8  = 3'b101,
    BUR_WRAP16 = 3'b110,
    BUR_INCR16 = 3'b111
  } hburst_e;

  // HSIZE encoding, log2 of the byte count
  typedef enum logic [2:0] {
    SZ_BYTE = 3'd0, SZ_HALF = 3'd1, SZ_WORD = 3'd2, SZ_DWORD = 3'd3,
    SZ_4WORD = 3'd4, SZ_8WORD = 3'd5, SZ_16WORD = 3'd6, SZ_32WORD = 3'd7
  } hsize_e;

  // HRESP encoding
  typedef enum logic [1:0] {
    RSP_OKAY  = 2'b00,
    RSP_ERROR = 2'b01,
    RSP_RETRY = 2'b10,
    RSP_SPLIT = 2'b11
  } hresp_e;

  // Input stage state: direct path or holding register
  typedef enum logic {ST_PASS = 1'b0, ST_HELD = 1'b1} stage_st_e;

  // Address/control bundle of one AHB address phase
  typedef struct packed {
    haddr_t   addr;     // HADDR
    htrans_e  trans;    // HTRANS
    logic     write;    // HWRITE
    hsize_e   size;     // HSIZE
    hburst_e  burst;    // HBURST
    hprot_t   prot;     // HPROT
    hmaster_t master;   // HMASTER
    logic     mastlock; // HMASTLOCK
  } ahb_ctl_t;

endpackage

// ==== hw/in_stage_ctrl.sv ====
// Input stage control with load strobe, data phase, pending-transfer FSM and response mux
`timescale 1ns/1ps

module in_stage_ctrl
  import ahb_in_pkg::*;
(
  input  logic    HCLK,         // AHB clock
  input  logic    HRESETn,      // Sync reset, active low
  input  logic    HSELS,        // Port select
  input  logic    HREADYS,      // Previous transfer done
  input  htrans_e in_trans,     // Transfer type from master
  input  logic    active_ip,    // Output stage drives this port
  input  logic    readyout_ip,  // Ready from output stage
  input  hresp_e  resp_ip,      // Response from output stage
  output logic    load_reg,     // Capture strobe for holding register
  output logic    held,         // Holding register selected
  output logic    held_tran_ip, // Request to output stage
  output logic    HREADYOUTS,   // Ready back to master
  output hresp_e  HRESPS        // Response back to master
);

  logic      addr_valid; // Active transfer addressed to this port
  logic      data_valid; // Data phase of an active transfer
  stage_st_e state_q;
  stage_st_e state_d;

  // ---------------------------------------------------------------------------
  // Address and data phase
  // ---------------------------------------------------------------------------

  assign addr_valid = HSELS & in_trans[1];   // NONSEQ or SEQ only
  assign load_reg   = addr_valid & HREADYS;

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (HREADYS)
      data_valid <= addr_valid;               // Advances with the bus pipeline
  end

  // ---------------------------------------------------------------------------
  // Pending-transfer FSM
  // ---------------------------------------------------------------------------

  // Loaded but output stage busy -> hold it
  // Output stage driving us and ready -> back to direct path
  always_comb
  begin
    state_d = state_q;
    if (load_reg && !active_ip)
      state_d = ST_HELD;
    else if (active_ip && readyout_ip)
      state_d = ST_PASS;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      state_q <= ST_PASS;
    else
      state_q <= state_d;
  end

  assign held         = (state_q == ST_HELD);
  assign held_tran_ip = load_reg | held;      // Request from address phase on

  // ---------------------------------------------------------------------------
  // Response mux
  // ---------------------------------------------------------------------------

  always_comb
  begin
    if (!data_valid)
    begin
      HREADYOUTS = 1'b1;                       // Idle, busy or not selected
      HRESPS     = RSP_OKAY;
    end
    else if (held)
    begin
      HREADYOUTS = 1'b0;                       // Stall master while pending
      HRESPS     = RSP_OKAY;
    end
    else
    begin
      HREADYOUTS = readyout_ip;
      HRESPS     = resp_ip;
    end
  end

  // Request stays up until the output stage picks this port
  a_held_req: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (held_tran_ip && !active_ip) |=> held_tran_ip);

endmodule

// ==== hw/hold_reg.sv ====
// Holding register for the address/control bundle and its direct-or-held mux
`timescale 1ns/1ps

module hold_reg
  import ahb_in_pkg::*;
(
  input  logic     HCLK,       // AHB clock
  input  logic     HRESETn,    // Sync reset, active low
  input  logic     load_reg,   // Capture the current address phase
  input  logic     held,       // Present the held transfer
  input  logic     HSELS,      // Direct port select
  input  ahb_ctl_t in_ctl,     // Direct address/control
  output logic     sel_ip,     // Select to output stage
  output ahb_ctl_t mux_ctl,    // Muxed address/control
  output htrans_e  held_trans  // Transfer type for burst selection
);

  ahb_ctl_t reg_ctl;  // Captured address/control
  htrans_e  reg_trans; // Captured transfer type

  // ---------------------------------------------------------------------------
  // Capture
  // ---------------------------------------------------------------------------

  // Captured transfer type steers the burst rewrite
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      reg_trans <= TRN_IDLE;
    else if (load_reg)
      reg_trans <= in_ctl.trans;
  end

  always_ff @(posedge HCLK)
  begin
    if (load_reg)
      reg_ctl <= in_ctl;                 // Every accepted address phase
  end

  // ---------------------------------------------------------------------------
  // Direct or held path
  // ---------------------------------------------------------------------------

  always_comb
  begin
    if (held)
    begin
      sel_ip        = 1'b1;
      mux_ctl       = reg_ctl;
      mux_ctl.trans = TRN_NONSEQ;        // Held transfer restarts as NONSEQ
    end
    else
    begin
      sel_ip  = HSELS;
      mux_ctl = in_ctl;
    end
  end

  // Original type of the output transfer before the NONSEQ rewrite
  assign held_trans = held ? reg_trans : in_ctl.trans;

endmodule

// ==== hw/wrap_bound.sv ====
// Wrap-boundary detector: flags the beat after the last one before a wrap
`timescale 1ns/1ps
`include "ahb_in_consts.svh"

module wrap_bound
  import ahb_in_pkg::*;
(
  input  logic    HCLK,      // AHB clock
  input  logic    HRESETn,   // Sync reset, active low
  input  logic    HREADYS,   // Address phase accepted
  input  haddr_t  in_addr,   // Address from master
  input  hsize_e  in_size,   // Transfer size from master
  input  hburst_e in_burst,  // Burst type from master
  input  htrans_e in_trans,  // Transfer type from master
  output logic    bound      // Previous beat was last before a wrap
);

  beat_ofs_t offset_addr; // Beat number within the largest wrap
  beat_ofs_t check_addr;  // Offset with unused upper bits forced
  logic      bound_next;
  logic      bound_en;

  // ---------------------------------------------------------------------------
  // Beat offset
  // ---------------------------------------------------------------------------

  always_comb
  begin
    if (in_size > hsize_e'(`AHB_MAX_SIZE_LOG2))
      offset_addr = in_addr[`AHB_OFS_W-1:0];              // Wide sizes, byte offset
    else
      offset_addr = beat_ofs_t'(in_addr >> in_size);      // Drop byte lanes
  end

  // ---------------------------------------------------------------------------
  // Boundary check
  // ---------------------------------------------------------------------------

  always_comb
  begin
    case (in_burst)
      BUR_WRAP4:  check_addr = {2'b11, offset_addr[1:0]};
      BUR_WRAP8:  check_addr = {1'b1, offset_addr[2:0]};
      BUR_WRAP16: check_addr = offset_addr;
      default:    check_addr = '0;                        // SINGLE and INCRx never wrap
    endcase
  end

  assign bound_next = &check_addr;        // Last beat before the wrap
  assign bound_en   = in_trans[1] & HREADYS; // Only NONSEQ/SEQ beats update it

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (bound_en)
      bound <= bound_next;
  end

endmodule

// ==== hw/burst_fix.sv ====
// Early burst termination with the override flag and HTRANS/HBURST rewriting
`timescale 1ns/1ps

module burst_fix
  import ahb_in_pkg::*;
(
  input  logic     HCLK,       // AHB clock
  input  logic     HRESETn,    // Sync reset, active low
  input  logic     HREADYS,    // Address phase accepted
  input  logic     load_reg,   // Transfer captured this cycle
  input  logic     active_ip,  // Output stage drives this port
  input  logic     bound,      // Wrap boundary was crossed
  input  htrans_e  in_trans,   // Transfer type from master
  input  ahb_ctl_t mux_ctl,    // Muxed address/control
  input  htrans_e  held_trans, // Original type of the output transfer
  output ahb_ctl_t out_ctl     // Address/control to output stage
);

  logic burst_override;      // Burst is being completed as INCR
  logic burst_override_next;

  // ---------------------------------------------------------------------------
  // Override flag
  // ---------------------------------------------------------------------------

  // A new burst or an idle ends the override
  // A SEQ beat that lands in the holding register starts one
  always_comb
  begin
    if (in_trans == TRN_NONSEQ || in_trans == TRN_IDLE)
      burst_override_next = 1'b0;
    else if (in_trans == TRN_SEQ && load_reg && !active_ip)
      burst_override_next = 1'b1;
    else
      burst_override_next = burst_override;          // BUSY keeps it
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      burst_override <= 1'b0;
    else if (HREADYS)
      burst_override <= burst_override_next;
  end

  // ---------------------------------------------------------------------------
  // Rewriting
  // ---------------------------------------------------------------------------

  always_comb
  begin
    out_ctl = mux_ctl;
    // Past the wrap point the INCR view breaks, so restart the sequence
    if (burst_override && bound)
      out_ctl.trans = htrans_e'({mux_ctl.trans[1], 1'b0}); // SEQ->NONSEQ, BUSY->IDLE
    if (burst_override && held_trans != TRN_NONSEQ)
      out_ctl.burst = BUR_INCR;                            // Undefined-length remainder
  end

  // An interrupted SEQ beat goes out as INCR from the next cycle on
  a_incr_ovr: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (load_reg && !active_ip && in_trans == TRN_SEQ)
      |=> (out_ctl.burst == BUR_INCR));

endmodule

// ==== hw/ahb_in_stage.sv ====
// AHB bus matrix input stage: holds a pending transfer until its output stage is free
`timescale 1ns/1ps

module ahb_in_stage
  import ahb_in_pkg::*;
(
  // Clock and reset
  input  logic     HCLK,          // AHB clock
  input  logic     HRESETn,       // Sync reset, active low

  // Master side
  input  logic     HSELS,         // Port select
  input  logic     HREADYS,       // Previous transfer done
  input  ahb_ctl_t in_ctl,        // Address/control from master
  output logic     HREADYOUTS,    // Ready back to master
  output hresp_e   HRESPS,        // Response back to master

  // Output stage side
  input  logic     active_ip,     // Output stage drives this port
  input  logic     readyout_ip,   // Ready from output stage
  input  hresp_e   resp_ip,       // Response from output stage
  output logic     sel_ip,        // Select to output stage
  output ahb_ctl_t out_ctl,       // Address/control to output stage
  output logic     held_tran_ip   // Arbitration request
);

  logic     load_reg;   // Address phase accepted on this port
  logic     held;       // Holding register on the output
  ahb_ctl_t mux_ctl;    // Direct or held bundle
  htrans_e  held_trans; // Type used for burst selection
  logic     bound;      // Wrap boundary crossed

  in_stage_ctrl u_ctrl (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .HSELS        (HSELS),
    .HREADYS      (HREADYS),
    .in_trans     (in_ctl.trans),
    .active_ip    (active_ip),
    .readyout_ip  (readyout_ip),
    .resp_ip      (resp_ip),
    .load_reg     (load_reg),
    .held         (held),
    .held_tran_ip (held_tran_ip),
    .HREADYOUTS   (HREADYOUTS),
    .HRESPS       (HRESPS)
  );

  hold_reg u_hold (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .load_reg   (load_reg),
    .held       (held),
    .HSELS      (HSELS),
    .in_ctl     (in_ctl),
    .sel_ip     (sel_ip),
    .mux_ctl    (mux_ctl),
    .held_trans (held_trans)
  );

  // Boundary check works on the raw master beats
  wrap_bound u_bound (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .HREADYS  (HREADYS),
    .in_addr  (in_ctl.addr),
    .in_size  (in_ctl.size),
    .in_burst (in_ctl.burst),
    .in_trans (in_ctl.trans),
    .bound    (bound)
  );

  burst_fix u_fix (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .HREADYS    (HREADYS),
    .load_reg   (load_reg),
    .active_ip  (active_ip),
    .bound      (bound),
    .in_trans   (in_ctl.trans),
    .mux_ctl    (mux_ctl),
    .held_trans (held_trans),
    .out_ctl    (out_ctl)
  );

endmodule

// ==== tb/tb_ahb_in_stage.sv ====
// Testbench for the AHB input stage with directed and random stimulus against a cycle model
`timescale 1ns/1ps

module tb_ahb_in_stage
  import ahb_in_pkg::*;
();

  localparam int RANDOM_CYCLES = 1000;
  localparam int MAX_CYCLES    = 2000;  // Directed part plus random mix is about 1100 cycles

  // Expected outputs of one cycle
  typedef struct packed {
    logic     sel;
    ahb_ctl_t ctl;
    logic     req;
    logic     ready;
    hresp_e   resp;
  } ref_out_t;

  logic     HCLK;
  logic     HRESETn;
  logic     HSELS;
  logic     HREADYS;
  ahb_ctl_t in_ctl;
  logic     active_ip;
  logic     readyout_ip;
  hresp_e   resp_ip;
  logic     HREADYOUTS;
  hresp_e   HRESPS;
  logic     sel_ip;
  ahb_ctl_t out_ctl;
  logic     held_tran_ip;

  // Model state and its next value
  logic     m_held;
  logic     m_held_n;
  logic     m_dv;
  logic     m_dv_n;
  logic     m_ovr;
  logic     m_ovr_n;
  logic     m_bound;
  logic     m_bound_n;
  ahb_ctl_t m_reg;
  ahb_ctl_t m_reg_n;

  int    errors;
  int    checks;
  int    cycles;
  int    tests;
  int    failed;
  int    test_errs;
  string cur_name;

  ahb_in_stage i_ahb_in_stage (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .HSELS        (HSELS),
    .HREADYS      (HREADYS),
    .in_ctl       (in_ctl),
    .HREADYOUTS   (HREADYOUTS),
    .HRESPS       (HRESPS),
    .active_ip    (active_ip),
    .readyout_ip  (readyout_ip),
    .resp_ip      (resp_ip),
    .sel_ip       (sel_ip),
    .out_ctl      (out_ctl),
    .held_tran_ip (held_tran_ip)
  );

  initial HCLK = 1'b0;
  always #50 HCLK = ~HCLK;  // 100 ns period

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------

  // True on the last beat before a wrap point
  function automatic logic last_before_wrap(haddr_t addr, hsize_e size, hburst_e burst);
    int unsigned beat;
    int unsigned len;
    if (size > SZ_DWORD)
      beat = 32'(addr[3:0]);             // Wide sizes count bytes
    else
      beat = (addr >> size) & 32'hF;
    case (burst)
      BUR_WRAP4:  len = 4;
      BUR_WRAP8:  len = 8;
      BUR_WRAP16: len = 16;
      default:    len = 0;
    endcase
    return (len != 0) && (beat % len == len - 1);
  endfunction

  // Returns this cycle's outputs and leaves the next state in the _n copies
  function automatic ref_out_t ref_step();
    ref_out_t o;
    logic     addr_ok;
    logic     load;
    htrans_e  src_trans;
    addr_ok   = HSELS && (in_ctl.trans inside {TRN_NONSEQ, TRN_SEQ});
    load      = addr_ok && HREADYS;
    src_trans = m_held ? m_reg.trans : in_ctl.trans;
    o.sel     = m_held ? 1'b1 : HSELS;
    o.ctl     = m_held ? m_reg : in_ctl;
    if (m_held)
      o.ctl.trans = TRN_NONSEQ;
    if (m_ovr && m_bound)
    begin
      if (o.ctl.trans == TRN_SEQ)
        o.ctl.trans = TRN_NONSEQ;
      else if (o.ctl.trans == TRN_BUSY)
        o.ctl.trans = TRN_IDLE;
    end
    if (m_ovr && src_trans != TRN_NONSEQ)
      o.ctl.burst = BUR_INCR;
    o.req   = load || m_held;
    o.ready = !m_dv ? 1'b1 : (m_held ? 1'b0 : readyout_ip);
    o.resp  = (!m_dv || m_held) ? RSP_OKAY : resp_ip;
    if (!HRESETn)
    begin
      m_held_n  = 1'b0;
      m_dv_n    = 1'b0;
      m_ovr_n   = 1'b0;
      m_bound_n = 1'b0;
      m_reg_n   = '0;
    end
    else
    begin
      if (load && !active_ip)
        m_held_n = 1'b1;
      else if (active_ip && readyout_ip)
        m_held_n = 1'b0;
      else
        m_held_n = m_held;
      m_dv_n  = HREADYS ? addr_ok : m_dv;
      m_reg_n = load ? in_ctl : m_reg;
      if (HREADYS && (in_ctl.trans inside {TRN_NONSEQ, TRN_SEQ}))
        m_bound_n = last_before_wrap(in_ctl.addr, in_ctl.size, in_ctl.burst);
      else
        m_bound_n = m_bound;
      if (!HREADYS)
        m_ovr_n = m_ovr;
      else if (in_ctl.trans == TRN_NONSEQ || in_ctl.trans == TRN_IDLE)
        m_ovr_n = 1'b0;
      else if (in_ctl.trans == TRN_SEQ && load && !active_ip)
        m_ovr_n = 1'b1;                  // Interrupted burst
      else
        m_ovr_n = m_ovr;
    end
    return o;
  endfunction

  // ---------------------------------------------------------------------------
  // Comparison 5 ns before each rising edge
  // ---------------------------------------------------------------------------

  initial
  begin
    ref_out_t exp;
    logic     primed;
    logic     checking;
    primed   = 1'b0;
    checking = 1'b0;
    forever
    begin
      @(posedge HCLK);
      if (primed)
      begin
        m_held  = m_held_n;
        m_dv    = m_dv_n;
        m_ovr   = m_ovr_n;
        m_bound = m_bound_n;
        m_reg   = m_reg_n;
        checking = 1'b1;
      end
      #95;
      exp = ref_step();
      if (!HRESETn)
        primed = 1'b1;                   // Model known from the next edge
      if (checking)
      begin
        checks++;
        if (sel_ip !== exp.sel)
        begin
          $display("MISMATCH sel_ip expected 0x%h actual 0x%h", exp.sel, sel_ip);
          errors++;
        end
        if (out_ctl !== exp.ctl)
        begin
          $display("MISMATCH out_ctl expected 0x%h actual 0x%h", exp.ctl, out_ctl);
          errors++;
        end
        if (held_tran_ip !== exp.req)
        begin
          $display("MISMATCH held_tran_ip expected 0x%h actual 0x%h", exp.req, held_tran_ip);
          errors++;
        end
        if (HREADYOUTS !== exp.ready)
        begin
          $display("MISMATCH HREADYOUTS expected 0x%h actual 0x%h", exp.ready, HREADYOUTS);
          errors++;
        end
        if (HRESPS !== exp.resp)
        begin
          $display("MISMATCH HRESPS expected 0x%h actual 0x%h", exp.resp, HRESPS);
          errors++;
        end
      end
    end
  end

  // Run limit
  always @(posedge HCLK)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // Stimulus helpers
  // ---------------------------------------------------------------------------

  task automatic next_cycle();
    @(posedge HCLK);
    #5;
  endtask

  task automatic set_beat(input logic sel, input htrans_e trans, input haddr_t addr,
                          input hburst_e burst, input logic rdy);
    HSELS           = sel;
    HREADYS         = rdy;
    in_ctl.addr     = addr;
    in_ctl.trans    = trans;
    in_ctl.write    = 1'b1;
    in_ctl.size     = SZ_WORD;
    in_ctl.burst    = burst;
    in_ctl.prot     = 4'h3;
    in_ctl.master   = 4'h1;
    in_ctl.mastlock = 1'b0;
  endtask

  task automatic check_val(input string name, input logic [7:0] act, input logic [7:0] exp);
    checks++;
    if (act !== exp)
    begin
      $display("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_name  = name;
    test_errs = errors;
    tests++;
  endtask

  task automatic finish_test();
    if (errors == test_errs)
      $display("test %s: ok", cur_name);
    else
    begin
      failed++;
      $display("test %s: FAILED with %0d errors", cur_name, errors - test_errs);
    end
  endtask

  // ---------------------------------------------------------------------------
  // Tests
  // ---------------------------------------------------------------------------

  initial
  begin
    logic [31:0] rnd;
    void'($urandom(32'h932d_604d));
    errors = 0;
    checks = 0;
    cycles = 0;
    tests  = 0;
    failed = 0;
    HRESETn     = 1'b0;
    HSELS       = 1'b0;
    HREADYS     = 1'b1;
    in_ctl      = '0;
    active_ip   = 1'b0;
    readyout_ip = 1'b1;
    resp_ip     = RSP_OKAY;

    start_test("reset");
    repeat (3) @(posedge HCLK);
    #5 HRESETn = 1'b1;
    #90;
    check_val("held_tran_ip", 8'(held_tran_ip), 8'h0);
    check_val("HREADYOUTS", 8'(HREADYOUTS), 8'h1);
    check_val("HRESPS", 8'(HRESPS), 8'(RSP_OKAY));
    check_val("sel_ip", 8'(sel_ip), 8'h0);
    finish_test();

    start_test("pass-through");
    next_cycle();
    active_ip = 1'b1;
    set_beat(1'b1, TRN_NONSEQ, 32'h1000, BUR_INCR, 1'b1);
    #90 check_val("sel_ip", 8'(sel_ip), 8'h1);
    next_cycle();
    set_beat(1'b1, TRN_SEQ, 32'h1004, BUR_INCR, 1'b0);   // Output stage stalls
    readyout_ip = 1'b0;
    resp_ip     = RSP_ERROR;
    #90 check_val("HREADYOUTS", 8'(HREADYOUTS), 8'h0);
    check_val("HRESPS", 8'(HRESPS), 8'(RSP_ERROR));
    next_cycle();
    HREADYS     = 1'b1;
    readyout_ip = 1'b1;
    resp_ip     = RSP_OKAY;
    next_cycle();
    set_beat(1'b0, TRN_IDLE, 32'h0, BUR_SINGLE, 1'b1);
    next_cycle();
    readyout_ip = 1'b0;                  // Ignored outside a data phase
    resp_ip     = RSP_ERROR;
    #90 check_val("HREADYOUTS", 8'(HREADYOUTS), 8'h1);      // No data phase
    check_val("HRESPS", 8'(HRESPS), 8'(RSP_OKAY));
    finish_test();

    start_test("hold");
    next_cycle();
    active_ip   = 1'b0;
    readyout_ip = 1'b1;
    resp_ip     = RSP_OKAY;
    set_beat(1'b1, TRN_NONSEQ, 32'h2000, BUR_WRAP4, 1'b1);
    #90 check_val("held_tran_ip", 8'(held_tran_ip), 8'h1);
    repeat (3)
    begin
      next_cycle();
      set_beat(1'b1, TRN_IDLE, 32'h2100, BUR_SINGLE, 1'b0);
      #90 check_val("sel_ip", 8'(sel_ip), 8'h1);
      check_val("out_ctl.trans", 8'(out_ctl.trans), 8'(TRN_NONSEQ));
      check_val("out_ctl.addr[15:8]", out_ctl.addr[15:8], 8'h20);
      check_val("HREADYOUTS", 8'(HREADYOUTS), 8'h0);
      check_val("held_tran_ip", 8'(held_tran_ip), 8'h1);
    end
    next_cycle();
    active_ip   = 1'b1;
    readyout_ip = 1'b0;
    #90 check_val("HREADYOUTS", 8'(HREADYOUTS), 8'h0);
    next_cycle();
    readyout_ip = 1'b1;                  // Hold ends at this edge
    #90 check_val("held_tran_ip", 8'(held_tran_ip), 8'h1);
    next_cycle();
    HREADYS = 1'b1;
    #90 check_val("held_tran_ip", 8'(held_tran_ip), 8'h0);
    finish_test();

    start_test("burst override");
    next_cycle();
    set_beat(1'b1, TRN_NONSEQ, 32'h3000, BUR_INCR8, 1'b1);
    next_cycle();
    active_ip = 1'b0;                    // SEQ beat gets interrupted
    set_beat(1'b1, TRN_SEQ, 32'h3004, BUR_INCR8, 1'b1);
    next_cycle();
    set_beat(1'b1, TRN_SEQ, 32'h3008, BUR_INCR8, 1'b0);
    #90 check_val("out_ctl.burst", 8'(out_ctl.burst), 8'(BUR_INCR));
    next_cycle();
    active_ip = 1'b1;
    next_cycle();
    set_beat(1'b1, TRN_SEQ, 32'h3008, BUR_INCR8, 1'b1);
    #90 check_val("out_ctl.burst", 8'(out_ctl.burst), 8'(BUR_INCR));
    next_cycle();
    set_beat(1'b1, TRN_SEQ, 32'h300C, BUR_INCR8, 1'b1);
    #90 check_val("out_ctl.burst", 8'(out_ctl.burst), 8'(BUR_INCR));
    next_cycle();
    set_beat(1'b1, TRN_NONSEQ, 32'h3100, BUR_INCR4, 1'b1);
    #90 check_val("out_ctl.burst", 8'(out_ctl.burst), 8'(BUR_INCR4));
    next_cycle();
    set_beat(1'b1, TRN_SEQ, 32'h3104, BUR_INCR4, 1'b1);
    #90 check_val("out_ctl.burst", 8'(out_ctl.burst), 8'(BUR_INCR4));
    finish_test();

    start_test("wrap boundary");
    // WRAP4 words with 0x400C as the last beat before the wrap
    next_cycle();
    set_beat(1'b1, TRN_NONSEQ, 32'h4008, BUR_WRAP4, 1'b1);
    next_cycle();
    active_ip = 1'b0;
    set_beat(1'b1, TRN_SEQ, 32'h400C, BUR_WRAP4, 1'b1);
    next_cycle();
    set_beat(1'b1, TRN_SEQ, 32'h4000, BUR_WRAP4, 1'b0);
    next_cycle();
    active_ip = 1'b1;
    next_cycle();
    HREADYS = 1'b1;
    #90 check_val("out_ctl.trans", 8'(out_ctl.trans), 8'(TRN_NONSEQ));
    check_val("out_ctl.burst", 8'(out_ctl.burst), 8'(BUR_INCR));
    next_cycle();
    set_beat(1'b1, TRN_SEQ, 32'h4004, BUR_WRAP4, 1'b1);
    #90 check_val("out_ctl.trans", 8'(out_ctl.trans), 8'(TRN_SEQ));
    next_cycle();
    set_beat(1'b0, TRN_IDLE, 32'h0, BUR_SINGLE, 1'b1);
    // WRAP8 words with a BUSY right after the boundary
    next_cycle();
    set_beat(1'b1, TRN_NONSEQ, 32'h5018, BUR_WRAP8, 1'b1);
    next_cycle();
    active_ip = 1'b0;
    set_beat(1'b1, TRN_SEQ, 32'h501C, BUR_WRAP8, 1'b1);
    next_cycle();
    set_beat(1'b1, TRN_BUSY, 32'h5000, BUR_WRAP8, 1'b0);
    next_cycle();
    active_ip = 1'b1;
    next_cycle();
    HREADYS = 1'b1;
    #90 check_val("out_ctl.trans", 8'(out_ctl.trans), 8'(TRN_IDLE));
    next_cycle();
    set_beat(1'b1, TRN_SEQ, 32'h5000, BUR_WRAP8, 1'b1);
    #90 check_val("out_ctl.trans", 8'(out_ctl.trans), 8'(TRN_NONSEQ));
    next_cycle();
    set_beat(1'b0, TRN_IDLE, 32'h0, BUR_SINGLE, 1'b1);
    finish_test();

    start_test("random mix");
    repeat (RANDOM_CYCLES)
    begin
      next_cycle();
      rnd = $urandom;
      HSELS           = rnd[0] | rnd[1];     // Mostly selected
      HREADYS         = rnd[2] | rnd[3];
      active_ip       = rnd[4] | rnd[5];
      readyout_ip     = rnd[6] | rnd[7];
      resp_ip         = hresp_e'(rnd[9:8] & {rnd[10], rnd[10]});
      in_ctl.trans    = htrans_e'(rnd[12:11]);
      in_ctl.burst    = hburst_e'(rnd[15:13]);
      in_ctl.size     = hsize_e'({rnd[16] & rnd[17], rnd[19:18]});
      in_ctl.write    = rnd[20];
      in_ctl.prot     = rnd[24:21];
      in_ctl.master   = rnd[28:25];
      in_ctl.mastlock = rnd[29];
      in_ctl.addr     = $urandom;
    end
    next_cycle();
    #90;
    finish_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+common
common/ahb_in_pkg.sv
hw/in_stage_ctrl.sv
hw/hold_reg.sv
hw/wrap_bound.sv
hw/burst_fix.sv
hw/ahb_in_stage.sv
tb/tb_ahb_in_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the AHB input stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -sv -f verilog.f \
  --top-module tb_ahb_in_stage -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "ERROR: Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "ERROR: simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  exit 0
fi
echo "ERROR: pass message not found in $LOG"
exit 1
